// File: filelist.f
+incdir+include
rtl/cpu_core_pkg.sv
rtl/pipe_bus_pkg.sv
rtl/wb_ifs.sv
rtl/io_stage.sv
rtl/wb_stage.sv
rtl/register_file.sv
rtl/cp0_regs.sv
rtl/wb_subsystem.sv
verif/tb_clock_gen.sv
verif/wb_checker.sv
verif/wb_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= wb_tb
RTL_TOP ?= wb_subsystem
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/wb_tb.sv
`timescale 1ns/10ps
`include "wb_cfg.svh"

module wb_tb;
  typedef struct {
    logic valid;
    logic [31:0] pc;
    logic [31:0] alu;
    logic [31:0] ldata;
    cpu_core_pkg::load_kind kind;
    logic [4:0] dest;
    logic reg_write;
    logic mtc0;
    logic mfc0;
    logic [4:0] cp0_reg;
    logic eret;
    logic syscall;
    logic dslot;
  } ms_record;

  localparam int random_count = 200;
  localparam int total_records = 360;

  logic clock, reset, ms_valid, ms_allow_in, flush;
  logic ms_reg_write, ms_mtc0, ms_mfc0, ms_eret, ms_syscall, ms_in_delay_slot;
  logic [31:0] ms_pc, ms_alu_result, ms_load_data, rdata1, rdata2, flush_pc;
  logic [31:0] debug_pc, debug_wdata;
  cpu_core_pkg::load_kind ms_load_kind;
  logic [4:0] ms_dest, ms_cp0_reg, raddr1, raddr2, debug_waddr;
  logic [3:0] debug_wen;

  // reference model state
  logic [31:0] model_regs [32];
  bit written [32];
  logic [31:0] m_status, m_cause, m_epc, m_badvaddr;
  int drop_left = 0;
  int tb_errors = 0;
  int seed = 38;
  int mark;
  string current_test = "reset";

  tb_clock_gen clk_gen (.clock(clock), .reset(reset));

  wb_subsystem dut (
    .clock(clock), .reset(reset), .ms_valid(ms_valid), .ms_pc(ms_pc),
    .ms_alu_result(ms_alu_result), .ms_load_data(ms_load_data),
    .ms_load_kind(ms_load_kind), .ms_dest(ms_dest), .ms_reg_write(ms_reg_write),
    .ms_mtc0(ms_mtc0), .ms_mfc0(ms_mfc0), .ms_cp0_reg(ms_cp0_reg), .ms_eret(ms_eret),
    .ms_syscall(ms_syscall), .ms_in_delay_slot(ms_in_delay_slot),
    .ms_allow_in(ms_allow_in), .raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1),
    .rdata2(rdata2), .flush(flush), .flush_pc(flush_pc), .debug_pc(debug_pc),
    .debug_wen(debug_wen), .debug_waddr(debug_waddr), .debug_wdata(debug_wdata)
  );

  wb_checker chk (
    .clock(clock), .reset(reset), .ms_allow_in(ms_allow_in), .flush(flush),
    .flush_pc(flush_pc), .debug_pc(debug_pc), .debug_wen(debug_wen),
    .debug_waddr(debug_waddr), .debug_wdata(debug_wdata)
  );

  function automatic ms_record make_rec(input logic [31:0] pc, input logic [4:0] dest,
                                        input logic [31:0] alu);
    ms_record r;
    r = '{valid: 1'b1, pc: pc, alu: alu, ldata: 32'h0, kind: cpu_core_pkg::load_none,
          dest: dest, reg_write: 1'b1, mtc0: 1'b0, mfc0: 1'b0,
          cp0_reg: 5'd0, eret: 1'b0, syscall: 1'b0, dslot: 1'b0};
    return r;
  endfunction

  function automatic logic [31:0] cp0_value(input logic [4:0] num);
    case (num)
      `WB_CP0_STATUS: return m_status;
      `WB_CP0_CAUSE: return m_cause;
      `WB_CP0_EPC: return m_epc;
      `WB_CP0_BADVADDR: return m_badvaddr;
      default: return 32'h0;
    endcase
  endfunction

  // expected trace entry for one pipeline slot
  function automatic void predict(input ms_record r);
    logic [7:0] b;
    logic [15:0] h;
    logic [31:0] value;
    logic misaligned;
    b = 8'(r.ldata >> (8 * r.alu[1:0]));
    h = 16'(r.ldata >> (16 * r.alu[1]));
    misaligned = ((r.kind == cpu_core_pkg::load_lh || r.kind == cpu_core_pkg::load_lhu)
                  && r.alu[0]) || (r.kind == cpu_core_pkg::load_lw && r.alu[1:0] != 0);
    if (drop_left > 0) begin
      drop_left--;
    end else if (r.valid && (misaligned || r.syscall)) begin
      m_epc = r.dslot ? r.pc - 32'd4 : r.pc;
      m_cause = {r.dslot, 24'h0, misaligned ? `WB_EXC_ADEL : `WB_EXC_SYS, 2'b00};
      if (misaligned) m_badvaddr = r.alu;
      m_status[1] = 1'b1;
      chk.add_expected(current_test, 1'b1, r.pc, `WB_EXC_ENTRY, 4'h0, 5'd0, 32'h0);
      drop_left = 2;
    end else if (r.valid && r.eret) begin
      chk.add_expected(current_test, 1'b1, r.pc, m_epc, 4'h0, 5'd0, 32'h0);
      m_status[1] = 1'b0;
      drop_left = 2;
    end else if (r.valid) begin
      case (r.kind)
        cpu_core_pkg::load_lb: value = {{24{b[7]}}, b};
        cpu_core_pkg::load_lbu: value = {24'h0, b};
        cpu_core_pkg::load_lh: value = {{16{h[15]}}, h};
        cpu_core_pkg::load_lhu: value = {16'h0, h};
        cpu_core_pkg::load_lw: value = r.ldata;
        default: value = r.mfc0 ? cp0_value(r.cp0_reg) : r.alu;
      endcase
      if (r.mtc0 && r.cp0_reg == `WB_CP0_STATUS)
        m_status = (m_status & ~`WB_STATUS_WMASK) | (r.alu & `WB_STATUS_WMASK);
      if (r.mtc0 && r.cp0_reg == `WB_CP0_EPC) m_epc = r.alu;
      if (r.reg_write) begin
        chk.add_expected(current_test, 1'b0, r.pc, 32'h0, 4'hf, r.dest, value);
        if (r.dest != 0) begin
          model_regs[r.dest] = value;
          written[r.dest] = 1'b1;
        end
      end
    end
  endfunction

  task automatic issue(input ms_record r);
    @(negedge clock);
    while (!ms_allow_in) @(negedge clock);
    ms_valid = r.valid;
    ms_pc = r.pc;
    ms_alu_result = r.alu;
    ms_load_data = r.ldata;
    ms_load_kind = r.kind;
    ms_dest = r.dest;
    ms_reg_write = r.reg_write;
    ms_mtc0 = r.mtc0;
    ms_mfc0 = r.mfc0;
    ms_cp0_reg = r.cp0_reg;
    ms_eret = r.eret;
    ms_syscall = r.syscall;
    ms_in_delay_slot = r.dslot;
    predict(r);
  endtask

  task automatic issue_special(input logic [31:0] pc, input int what, input logic [4:0] num,
                               input logic [4:0] dest, input logic [31:0] v);
    ms_record r;
    r = make_rec(pc, dest, v);
    r.reg_write = (what == 1);
    r.mtc0 = (what == 0);
    r.mfc0 = (what == 1);
    r.eret = (what == 2);
    r.syscall = (what == 3);
    r.cp0_reg = num;
    issue(r);
  endtask

  task automatic finish_test();
    ms_record idle;
    idle = make_rec(0, 0, 0);
    idle.valid = 1'b0;
    repeat (3) issue(idle);
    while (chk.pending() != 0) @(negedge clock);
    repeat (3) @(negedge clock);
    $display("test %s finished, %0d errors", current_test,
             tb_errors + chk.error_count - mark);
    mark = tb_errors + chk.error_count;
  endtask

  task automatic check_reg(input logic [4:0] a);
    @(negedge clock);
    raddr1 = a;
    raddr2 = a;
    #1;
    if (rdata1 !== model_regs[a] || rdata2 !== model_regs[a]) begin
      $display("MISMATCH %s: r%0d expected %h actual %h/%h", current_test, a,
               model_regs[a], rdata1, rdata2);
      tb_errors++;
    end
  endtask

  initial begin
    #((total_records + 20) * 4 * 2);
    $display("timeout: the DUT did not finish the tests in time");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    ms_record r;
    logic [31:0] pc;
    int pick;
    {ms_valid, ms_pc, ms_alu_result, ms_load_data, ms_dest, ms_reg_write} = '0;
    {ms_mtc0, ms_mfc0, ms_cp0_reg, ms_eret, ms_syscall, ms_in_delay_slot} = '0;
    ms_load_kind = cpu_core_pkg::load_none;
    raddr1 = 5'd0;
    raddr2 = 5'd0;
    pc = 32'h0000_1000;
    foreach (model_regs[i]) model_regs[i] = 32'h0;
    m_status = 32'h0040_0000;
    {m_cause, m_epc, m_badvaddr} = '0;
    @(negedge clock);
    while (reset) @(negedge clock);

    current_test = "after_reset";
    if (flush !== 1'b0 || debug_wen !== 4'h0) begin
      $display("flush or debug_wen is not low after reset");
      tb_errors++;
    end
    issue_special(pc, 1, `WB_CP0_STATUS, 5'd7, 0);
    finish_test();

    current_test = "alu_writes";
    repeat (24) begin
      pc += 4;
      issue(make_rec(pc, 5'($unsigned($random(seed)) % 32), $random(seed)));
    end
    issue(make_rec(pc + 4, 5'd0, 32'hdead_beef));
    finish_test();
    for (int i = 0; i < 32; i++) if (written[i] || i == 0) check_reg(i[4:0]);

    current_test = "loads";
    for (int k = 1; k <= 5; k++) begin
      for (int off = 0; off < 4; off++) begin
        if (k >= 3 && off % 2 == 1) continue;
        if (k == 5 && off != 0) continue;
        pc += 4;
        r = make_rec(pc, 5'd10 + k[4:0], 32'h0000_2000 + off);
        r.kind = cpu_core_pkg::load_kind'(k);
        r.ldata = 32'h8a7f_c531 ^ (off << 12);
        issue(r);
      end
    end
    finish_test();

    current_test = "exceptions";
    r = make_rec(32'h0000_0400, 5'd3, 32'h0000_3001);
    r.kind = cpu_core_pkg::load_lh;
    issue(r);
    r = make_rec(32'h0000_0500, 5'd4, 32'h0000_3006);
    r.kind = cpu_core_pkg::load_lw;
    r.dslot = 1'b1;
    for (int n = 0; n < 2; n++) begin
      issue(make_rec(32'h0000_0404, 5'd20, 32'h1111_1111));
      issue(make_rec(32'h0000_0408, 5'd21, 32'h2222_2222));
      issue_special(32'h0000_0600, 1, `WB_CP0_BADVADDR, 5'd5, 0);
      issue_special(32'h0000_0604, 1, `WB_CP0_EPC, 5'd6, 0);
      issue_special(32'h0000_0608, 1, `WB_CP0_CAUSE, 5'd7, 0);
      if (n == 0) issue(r);
    end
    issue_special(32'h0000_0700, 3, 0, 0, 0);
    issue(make_rec(32'h0000_0704, 5'd22, 32'h3333_3333));
    issue(make_rec(32'h0000_0708, 5'd23, 32'h4444_4444));
    issue_special(32'h0000_070c, 1, `WB_CP0_CAUSE, 5'd7, 0);
    finish_test();

    current_test = "mtc0_eret";
    issue_special(32'h0000_0800, 0, `WB_CP0_STATUS, 0, 32'hffff_ffff);
    issue_special(32'h0000_0804, 1, `WB_CP0_STATUS, 5'd8, 0);
    issue_special(32'h0000_0808, 0, `WB_CP0_EPC, 0, 32'h0000_3000);
    issue_special(32'h0000_080c, 2, 0, 0, 0);
    issue(make_rec(32'h0000_0810, 5'd24, 32'h5555_5555));
    issue(make_rec(32'h0000_0814, 5'd25, 32'h6666_6666));
    issue_special(32'h0000_3000, 1, `WB_CP0_STATUS, 5'd8, 0);
    finish_test();

    current_test = "random_mix";
    repeat (random_count) begin
      pick = $unsigned($random(seed)) % 16;
      pc += 4;
      r = make_rec(pc, 5'(1 + $unsigned($random(seed)) % 31), $random(seed));
      if (pick >= 6 && pick < 12) begin
        r.kind = cpu_core_pkg::load_kind'(1 + $unsigned($random(seed)) % 5);
        r.ldata = $random(seed);
        r.dslot = pick[0];
      end else if (pick == 12) begin
        r.syscall = 1'b1;
        r.reg_write = 1'b0;
      end else if (pick == 13) begin
        r.eret = 1'b1;
        r.reg_write = 1'b0;
      end else if (pick >= 14) begin
        r.mfc0 = 1'b1;
        r.cp0_reg = pick[0] ? `WB_CP0_EPC : `WB_CP0_CAUSE;
      end
      issue(r);
    end
    finish_test();

    $display("tests done: %0d checker errors, %0d testbench errors", chk.error_count,
             tb_errors);
    if (chk.error_count == 0 && tb_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end
endmodule : wb_tb

// File: verif/wb_checker.sv
`timescale 1ns/10ps

module wb_checker (
  input logic clock,
  input logic reset,
  input logic ms_allow_in,
  input logic flush,
  input logic [31:0] flush_pc,
  input logic [31:0] debug_pc,
  input logic [3:0] debug_wen,
  input logic [4:0] debug_waddr,
  input logic [31:0] debug_wdata
);
  typedef struct {
    string name;
    bit is_flush;
    logic [31:0] pc;
    logic [31:0] target;
    logic [3:0] wen;
    logic [4:0] waddr;
    logic [31:0] wdata;
  } trace_entry;

  trace_entry expected[$];
  trace_entry head;
  int error_count = 0;

  function automatic void add_expected(input string name, input bit is_flush,
                                       input logic [31:0] pc, input logic [31:0] target,
                                       input logic [3:0] wen, input logic [4:0] waddr,
                                       input logic [31:0] wdata);
    trace_entry e;
    e.name = name;
    e.is_flush = is_flush;
    e.pc = pc;
    e.target = target;
    e.wen = wen;
    e.waddr = waddr;
    e.wdata = wdata;
    expected.push_back(e);
  endfunction

  function automatic int pending();
    return expected.size();
  endfunction

  // outputs are registered, so mid-cycle is settled
  always @(negedge clock) begin
    if (!reset && ms_allow_in !== 1'b1) begin
      $display("ms_allow_in is low at %0t although no stage stalls", $time);
      error_count++;
    end
    if (!reset && (flush || debug_wen != 4'b0000)) begin
      if (expected.size() == 0) begin
        $display("unexpected trace activity at %0t with no entry expected", $time);
        error_count++;
      end else begin
        head = expected.pop_front();
        if (head.is_flush != flush) begin
          $display("%s: expected %s but the DUT gave %s at %0t", head.name,
                   head.is_flush ? "a flush" : "a register write",
                   flush ? "a flush" : "a register write", $time);
          error_count++;
        end else if (flush && {flush_pc, debug_pc} !== {head.target, head.pc}) begin
          $display("MISMATCH %s: flush_pc/debug_pc expected %h/%h actual %h/%h", head.name,
                   head.target, head.pc, flush_pc, debug_pc);
          error_count++;
        end else if (!flush && {debug_pc, debug_wen, debug_waddr, debug_wdata} !==
                     {head.pc, head.wen, head.waddr, head.wdata}) begin
          $display("MISMATCH %s: trace expected %h/%h/%0d/%h actual %h/%h/%0d/%h",
                   head.name, head.pc, head.wen, head.waddr, head.wdata,
                   debug_pc, debug_wen, debug_waddr, debug_wdata);
          error_count++;
        end
      end
    end
  end
endmodule : wb_checker

// File: verif/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);
  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // release on a falling edge clear of the DUT's sampling edge
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end
endmodule : tb_clock_gen

// File: rtl/wb_subsystem.sv
`timescale 1ns/10ps

module wb_subsystem (
  input logic clock,
  input logic reset,
  input logic ms_valid,
  input cpu_core_pkg::program_count ms_pc,
  input cpu_core_pkg::cpu_data ms_alu_result,
  input cpu_core_pkg::cpu_data ms_load_data,
  input cpu_core_pkg::load_kind ms_load_kind,
  input cpu_core_pkg::reg_addr ms_dest,
  input logic ms_reg_write,
  input logic ms_mtc0,
  input logic ms_mfc0,
  input logic [4:0] ms_cp0_reg,
  input logic ms_eret,
  input logic ms_syscall,
  input logic ms_in_delay_slot,
  output logic ms_allow_in,
  input cpu_core_pkg::reg_addr raddr1,
  input cpu_core_pkg::reg_addr raddr2,
  output cpu_core_pkg::cpu_data rdata1,
  output cpu_core_pkg::cpu_data rdata2,
  output logic flush,
  output cpu_core_pkg::program_count flush_pc,
  output cpu_core_pkg::program_count debug_pc,
  output logic [3:0] debug_wen,
  output cpu_core_pkg::reg_addr debug_waddr,
  output cpu_core_pkg::cpu_data debug_wdata
);
  pipe_bus_pkg::ms_to_io_data ms_bus;
  pipe_bus_pkg::wb_to_cp0_data cp0_bus;
  cpu_core_pkg::cp0_word cp0_read_data;

  io_wb_if io_wb ();
  wb_rf_if wb_rf ();

  assign ms_bus = '{
    valid: ms_valid,
    pc: ms_pc,
    alu_result: ms_alu_result,
    load_data: ms_load_data,
    load_kind: ms_load_kind,
    dest: ms_dest,
    reg_write: ms_reg_write,
    mtc0: ms_mtc0,
    mfc0: ms_mfc0,
    cp0_reg: ms_cp0_reg,
    eret: ms_eret,
    syscall: ms_syscall,
    in_delay_slot: ms_in_delay_slot
  };

  io_stage u_io_stage (
    .clock(clock),
    .reset(reset),
    .in_bus(ms_bus),
    .allow_in(ms_allow_in),
    .wb(io_wb.producer)
  );

  wb_stage u_wb_stage (
    .clock(clock),
    .reset(reset),
    .io(io_wb.consumer),
    .rf(wb_rf.writer),
    .cp0_bus(cp0_bus),
    .cp0_read_data(cp0_read_data),
    .have_exception(flush),
    .debug_pc(debug_pc),
    .debug_wen(debug_wen),
    .debug_waddr(debug_waddr),
    .debug_wdata(debug_wdata)
  );

  register_file u_register_file (
    .clock(clock),
    .wr(wb_rf.file),
    .raddr1(raddr1),
    .raddr2(raddr2),
    .rdata1(rdata1),
    .rdata2(rdata2)
  );

  cp0_regs u_cp0_regs (
    .clock(clock),
    .reset(reset),
    .wb_bus(cp0_bus),
    .read_data(cp0_read_data),
    .flush_target(flush_pc)
  );

endmodule : wb_subsystem

// File: rtl/cp0_regs.sv
`timescale 1ns/10ps
`include "wb_cfg.svh"

module cp0_regs (
  input logic clock,
  input logic reset,
  input pipe_bus_pkg::wb_to_cp0_data wb_bus,
  output cpu_core_pkg::cp0_word read_data,
  output cpu_core_pkg::program_count flush_target
);
  cpu_core_pkg::cp0_word status;
  cpu_core_pkg::cp0_word cause;
  cpu_core_pkg::cpu_data epc;
  cpu_core_pkg::cpu_data badvaddr;
  logic status_write;
  logic epc_write;

  assign status_write = wb_bus.write_enabled && (wb_bus.cp0_reg == `WB_CP0_STATUS);
  assign epc_write = wb_bus.write_enabled && (wb_bus.cp0_reg == `WB_CP0_EPC);

  always_ff @(posedge clock) begin
    if (reset) begin
      status.raw <= '0;
      status.status.bev <= 1'b1;
    end else if (wb_bus.exc_valid) begin
      status.status.exl <= 1'b1;
    end else if (wb_bus.eret_flush) begin
      status.status.exl <= 1'b0;
    end else if (status_write) begin
      status.raw <= (status.raw & ~`WB_STATUS_WMASK) | (wb_bus.write_data & `WB_STATUS_WMASK);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      cause.raw <= '0;
    end else if (wb_bus.exc_valid) begin
      cause.cause.bd <= wb_bus.in_delay_slot;
      cause.cause.exc_code <= wb_bus.exc_code;
    end
  end

  // delay-slot faults restart at the branch
  always_ff @(posedge clock) begin
    if (wb_bus.exc_valid) begin
      epc <= wb_bus.in_delay_slot ? wb_bus.exc_address - 32'd4 : wb_bus.exc_address;
    end else if (epc_write) begin
      epc <= wb_bus.write_data;
    end
  end

  always_ff @(posedge clock) begin
    if (wb_bus.exc_valid && wb_bus.addr_fault) begin
      badvaddr <= wb_bus.badvaddr;
    end
  end

  always_comb begin
    case (wb_bus.cp0_reg)
      `WB_CP0_STATUS: read_data.raw = status.raw;
      `WB_CP0_CAUSE: read_data.raw = cause.raw;
      `WB_CP0_EPC: read_data.raw = epc;
      `WB_CP0_BADVADDR: read_data.raw = badvaddr;
      default: read_data.raw = '0;
    endcase
  end

  assign flush_target = wb_bus.eret_flush ? epc : `WB_EXC_ENTRY;

  exc_eret_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(wb_bus.exc_valid && wb_bus.eret_flush));

endmodule : cp0_regs

// File: rtl/register_file.sv
`timescale 1ns/10ps
`include "wb_cfg.svh"

module register_file (
  input logic clock,
  wb_rf_if.file wr,
  input cpu_core_pkg::reg_addr raddr1,
  input cpu_core_pkg::reg_addr raddr2,
  output cpu_core_pkg::cpu_data rdata1,
  output cpu_core_pkg::cpu_data rdata2
);
  cpu_core_pkg::cpu_data regs [`WB_REG_COUNT];
  logic write_hit;

  // r0 is hardwired
  assign write_hit = wr.write_enabled && (wr.write_address != 5'd0);

  always_ff @(posedge clock) begin
    if (write_hit) begin
      for (int i = 0; i < 4; i++) begin
        if (wr.write_strobe[i]) begin
          regs[wr.write_address][8*i +: 8] <= wr.write_data[8*i +: 8];
        end
      end
    end
  end

  // async read
  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule : register_file

// File: rtl/wb_stage.sv
`timescale 1ns/10ps

module wb_stage (
  input logic clock,
  input logic reset,
  io_wb_if.consumer io,
  wb_rf_if.writer rf,
  output pipe_bus_pkg::wb_to_cp0_data cp0_bus,
  input cpu_core_pkg::cp0_word cp0_read_data,
  output logic have_exception,
  output cpu_core_pkg::program_count debug_pc,
  output logic [3:0] debug_wen,
  output cpu_core_pkg::reg_addr debug_waddr,
  output cpu_core_pkg::cpu_data debug_wdata
);
  logic wb_valid;
  pipe_bus_pkg::io_to_wb_data from_io;
  cpu_core_pkg::cpu_data write_data;

  // never stalls
  assign io.allow_in = 1'b1;

  assign have_exception = wb_valid && (from_io.exc_valid || from_io.eret);
  assign io.flush = have_exception;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else if (have_exception) begin
      wb_valid <= 1'b0;
    end else if (io.allow_in) begin
      wb_valid <= io.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (io.valid && io.allow_in) begin
      from_io <= io.data;
    end
  end

  assign io.read_data = cp0_read_data.raw;
  assign write_data = from_io.mfc0 ? io.read_data : from_io.final_result;

  assign rf.write_enabled = wb_valid && from_io.reg_write && !from_io.exc_valid;
  assign rf.write_address = from_io.dest;
  assign rf.write_strobe = from_io.write_strobe;
  assign rf.write_data = write_data;

  assign cp0_bus = '{
    write_enabled: wb_valid && from_io.mtc0,
    cp0_reg: from_io.cp0_reg,
    write_data: from_io.final_result,
    exc_valid: wb_valid && from_io.exc_valid,
    exc_address: from_io.pc,
    eret_flush: wb_valid && from_io.eret,
    in_delay_slot: from_io.in_delay_slot,
    exc_code: from_io.exc_code,
    addr_fault: from_io.addr_fault,
    badvaddr: from_io.badvaddr
  };

  // trace port
  assign debug_pc = from_io.pc;
  assign debug_wen = {4{rf.write_enabled}} & from_io.write_strobe;
  assign debug_waddr = from_io.dest;
  assign debug_wdata = write_data;

  no_write_on_exception: assert property (@(posedge clock) disable iff (reset)
    !(rf.write_enabled && have_exception));

endmodule : wb_stage

// File: rtl/io_stage.sv
`timescale 1ns/10ps
`include "wb_cfg.svh"

module io_stage (
  input logic clock,
  input logic reset,
  input pipe_bus_pkg::ms_to_io_data in_bus,
  output logic allow_in,
  io_wb_if.producer wb
);
  logic io_valid;
  pipe_bus_pkg::ms_to_io_data ms_data;
  logic [1:0] offset;
  logic [7:0] load_byte;
  logic [15:0] load_half;
  logic addr_error;
  logic exc_valid;
  cpu_core_pkg::cpu_data final_result;

  // no stall source in this stage
  assign allow_in = !io_valid || wb.allow_in;

  always_ff @(posedge clock) begin
    if (reset || wb.flush) begin
      io_valid <= 1'b0;
    end else if (allow_in) begin
      io_valid <= in_bus.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in_bus.valid && allow_in) begin
      ms_data <= in_bus;
    end
  end

  assign offset = ms_data.alu_result[1:0];
  assign load_byte = ms_data.load_data[{offset, 3'b000} +: 8];
  assign load_half = ms_data.load_data[{offset[1], 4'b0000} +: 16];

  always_comb begin
    case (ms_data.load_kind)
      cpu_core_pkg::load_lb: final_result = {{24{load_byte[7]}}, load_byte};
      cpu_core_pkg::load_lbu: final_result = {24'b0, load_byte};
      cpu_core_pkg::load_lh: final_result = {{16{load_half[15]}}, load_half};
      cpu_core_pkg::load_lhu: final_result = {16'b0, load_half};
      cpu_core_pkg::load_lw: final_result = ms_data.load_data;
      default: final_result = ms_data.alu_result;
    endcase
  end

  // halfword needs bit 0 clear, word needs both
  always_comb begin
    case (ms_data.load_kind)
      cpu_core_pkg::load_lh,
      cpu_core_pkg::load_lhu: addr_error = offset[0];
      cpu_core_pkg::load_lw: addr_error = |offset;
      default: addr_error = 1'b0;
    endcase
  end

  assign exc_valid = addr_error || ms_data.syscall;

  assign wb.valid = io_valid;
  assign wb.data = '{
    pc: ms_data.pc,
    final_result: final_result,
    reg_write: ms_data.reg_write && !exc_valid,
    write_strobe: 4'b1111,
    dest: ms_data.dest,
    mtc0: ms_data.mtc0,
    mfc0: ms_data.mfc0,
    cp0_reg: ms_data.cp0_reg,
    exc_valid: exc_valid,
    exc_code: addr_error ? `WB_EXC_ADEL : `WB_EXC_SYS,
    addr_fault: addr_error,
    badvaddr: ms_data.alu_result,
    eret: ms_data.eret,
    in_delay_slot: ms_data.in_delay_slot
  };

  // wb holds a faulting record for one cycle only
  flush_single_cycle: assert property (@(posedge clock) disable iff (reset)
    wb.flush |=> !wb.flush);

endmodule : io_stage

// File: rtl/wb_ifs.sv
`timescale 1ns/10ps

// io stage to write-back with valid/allow_in handshake
interface io_wb_if;
  logic valid;
  pipe_bus_pkg::io_to_wb_data data;
  logic allow_in;
  logic flush;
  // cp0 read result for mfc0 on the wb side
  cpu_core_pkg::cpu_data read_data;

  modport producer (
    output valid,
    output data,
    input allow_in,
    input flush
  );

  modport consumer (
    input valid,
    input data,
    output allow_in,
    output flush,
    output read_data
  );
endinterface : io_wb_if

interface wb_rf_if;
  logic write_enabled;
  cpu_core_pkg::reg_addr write_address;
  logic [3:0] write_strobe;
  cpu_core_pkg::cpu_data write_data;

  modport writer (
    output write_enabled,
    output write_address,
    output write_strobe,
    output write_data
  );

  modport file (
    input write_enabled,
    input write_address,
    input write_strobe,
    input write_data
  );
endinterface : wb_rf_if

// File: rtl/pipe_bus_pkg.sv
package pipe_bus_pkg;

  // memory stage hand-over
  typedef struct packed {
    logic valid;
    cpu_core_pkg::program_count pc;
    // load address for loads, rt value for mtc0
    cpu_core_pkg::cpu_data alu_result;
    cpu_core_pkg::cpu_data load_data;
    cpu_core_pkg::load_kind load_kind;
    cpu_core_pkg::reg_addr dest;
    logic reg_write;
    logic mtc0;
    logic mfc0;
    logic [4:0] cp0_reg;
    logic eret;
    logic syscall;
    logic in_delay_slot;
  } ms_to_io_data;

  typedef struct packed {
    cpu_core_pkg::program_count pc;
    cpu_core_pkg::cpu_data final_result;
    logic reg_write;
    logic [3:0] write_strobe;
    cpu_core_pkg::reg_addr dest;
    logic mtc0;
    logic mfc0;
    logic [4:0] cp0_reg;
    logic exc_valid;
    logic [4:0] exc_code;
    logic addr_fault;
    cpu_core_pkg::cpu_data badvaddr;
    logic eret;
    logic in_delay_slot;
  } io_to_wb_data;

  typedef struct packed {
    logic write_enabled;
    logic [4:0] cp0_reg;
    cpu_core_pkg::cpu_data write_data;
    logic exc_valid;
    cpu_core_pkg::program_count exc_address;
    logic eret_flush;
    logic in_delay_slot;
    logic [4:0] exc_code;
    logic addr_fault;
    cpu_core_pkg::cpu_data badvaddr;
  } wb_to_cp0_data;

endpackage : pipe_bus_pkg

// File: rtl/cpu_core_pkg.sv
package cpu_core_pkg;

  typedef logic [31:0] cpu_data;
  typedef logic [31:0] program_count;
  typedef logic [4:0] reg_addr;

  typedef enum logic [2:0] {
    load_none,
    load_lb,
    load_lbu,
    load_lh,
    load_lhu,
    load_lw
  } load_kind;

  typedef struct packed {
    logic [8:0] zero_hi;
    logic bev;
    logic [5:0] zero_mid;
    logic [7:0] im;
    logic [5:0] zero_lo;
    logic exl;
    logic ie;
  } status_view;

  typedef struct packed {
    logic bd;
    logic [14:0] zero_hi;
    logic [7:0] ip;
    logic zero_mid;
    logic [4:0] exc_code;
    logic [1:0] zero_lo;
  } cause_view;

  // register number picks the view
  typedef union packed {
    cpu_data raw;
    status_view status;
    cause_view cause;
  } cp0_word;

endpackage : cpu_core_pkg

// File: include/wb_cfg.svh
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// exception vector with bev set
`define WB_EXC_ENTRY 32'hbfc00380

`define WB_REG_COUNT 32

// cause.exc_code values
`define WB_EXC_ADEL 5'd4
`define WB_EXC_SYS 5'd8

// cp0 register numbers for select 0
`define WB_CP0_BADVADDR 5'd8
`define WB_CP0_STATUS 5'd12
`define WB_CP0_CAUSE 5'd13
`define WB_CP0_EPC 5'd14

// writable status bits are im[15:8], exl and ie
`define WB_STATUS_WMASK 32'h0000ff03

`endif
